// File: Bender.yml
package:
  name: yolo_accel

export_include_dirs:
  - include

sources:
  - files:
      - verilog/yolo_pkg.sv
      - verilog/cfg_decode.sv
      - verilog/vec_fetch.sv
      - verilog/mac_datapath.sv
      - verilog/result_store.sv
      - verilog/yolo_accel.sv
  - target: test
    files:
      - verif/yolo_properties.sv
      - verif/yolo_checker.sv
      - verif/yolo_accel_tb.sv

// File: include/yolo_params.svh
`ifndef YOLO_PARAMS_SVH
`define YOLO_PARAMS_SVH

// cpu port
`define YOLO_ADDR_W      32
`define YOLO_DATA_W      32

// native read and write databuses
`define YOLO_BUS_W       64
`define YOLO_MEM_ADDR_W  32
`define YOLO_LANES       4

// configuration registers, selected by addr[4:2]
`define YOLO_REG_RD_BASE 3'd0
`define YOLO_REG_WR_BASE 3'd1
`define YOLO_REG_GEOM    3'd2
`define YOLO_REG_COEF    3'd3
`define YOLO_REG_BIAS    3'd4

// command decode, top bit marks a command and the next one selects clear
`define YOLO_CMD_BIT     (`YOLO_ADDR_W-1)
`define YOLO_CLR_BIT     (`YOLO_ADDR_W-2)
`endif

// File: sources.f
+incdir+include
verilog/yolo_pkg.sv
verilog/cfg_decode.sv
verilog/vec_fetch.sv
verilog/mac_datapath.sv
verilog/result_store.sv
verilog/yolo_accel.sv
verif/yolo_properties.sv
verif/yolo_checker.sv
verif/yolo_accel_tb.sv

// File: verif/yolo_accel_tb.sv
`timescale 1ns/1ps
`include "yolo_params.svh"

module yolo_accel_tb;

   localparam int clk_period  = 100;
   // total words over all layers for the watchdog budget
   localparam int total_words = 42;
   localparam logic [`YOLO_ADDR_W-1:0] run_addr   = 32'd1 << `YOLO_CMD_BIT;
   localparam logic [`YOLO_ADDR_W-1:0] clear_addr = run_addr | (32'd1 << `YOLO_CLR_BIT);

   logic                        clk;
   logic                        rst;
   logic                        valid;
   logic [`YOLO_ADDR_W-1:0]     addr;
   logic [`YOLO_DATA_W-1:0]     wdata;
   logic                        wstrb;
   logic                        ready;
   logic [`YOLO_DATA_W-1:0]     rdata;
   logic                        rd_valid;
   logic [`YOLO_MEM_ADDR_W-1:0] rd_addr;
   logic [`YOLO_BUS_W-1:0]      rd_rdata;
   logic                        rd_ready;
   logic                        wr_valid;
   logic [`YOLO_MEM_ADDR_W-1:0] wr_addr;
   logic [`YOLO_BUS_W-1:0]      wr_wdata;
   logic [`YOLO_BUS_W/8-1:0]    wr_wstrb;
   logic                        wr_ready;

   logic [`YOLO_BUS_W-1:0] mem [0:255];
   logic [15:0]            lfsr = 16'd92;
   logic                   rd_pend = 1'b0;
   logic                   wr_pend = 1'b0;
   int                     rd_wait;
   int                     wr_wait;
   logic                   long_stall = 1'b0;
   int                     status_errors = 0;

   yolo_accel dut (
      .clk(clk), .rst(rst), .valid(valid), .addr(addr), .wdata(wdata), .wstrb(wstrb),
      .ready(ready), .rdata(rdata),
      .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_rdata(rd_rdata), .rd_ready(rd_ready),
      .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_wdata(wr_wdata), .wr_wstrb(wr_wstrb),
      .wr_ready(wr_ready)
   );

   yolo_checker chk (
      .clk(clk), .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr),
      .wr_wdata(wr_wdata), .wr_wstrb(wr_wstrb)
   );

   bind yolo_accel yolo_properties props (
      .clk(clk), .rst(rst), .rd_valid(rd_valid), .wr_valid(wr_valid),
      .wr_ready(wr_ready), .wr_addr(wr_addr), .wr_wdata(wr_wdata), .run(run)
   );

   // galois lfsr stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [31:0] rand_bias();
      logic [15:0] b;
      b = rand_bits(16);
      return {{16{b[15]}}, b};
   endfunction

   // lanes kept to 11 bits so most results stay inside the clamp
   function automatic logic [`YOLO_BUS_W-1:0] rand_word();
      logic [`YOLO_BUS_W-1:0] w;
      logic [10:0]            v;
      for (int i = 0; i < `YOLO_LANES; i++) begin
         v = rand_bits(11);
         w[16*i +: 16] = {{5{v[10]}}, v};
      end
      return w;
   endfunction

   // dot product plus bias, shift, leaky relu on the negative side, then clamp
   function automatic logic [`YOLO_BUS_W-1:0] expected_result(
         input logic [`YOLO_BUS_W-1:0] w, input logic [31:0] coefs,
         input logic [31:0] bias, input logic [3:0] shift);
      longint             acc;
      logic signed [15:0] lane;
      logic signed [7:0]  c;
      acc = longint'($signed(bias));
      for (int i = 0; i < `YOLO_LANES; i++) begin
         lane = w[16*i +: 16];
         c    = coefs[8*i +: 8];
         acc  = acc + longint'(lane) * longint'(c);
      end
      acc = acc >>> shift;
      if (acc < 0) begin
         acc = acc >>> 3;
      end
      if (acc > 32767) begin
         acc = 32767;
      end else if (acc < -32768) begin
         acc = -32768;
      end
      return {{48{acc[15]}}, acc[15:0]};
   endfunction

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // memory model picks delays at the falling edge and answers after the rising edge
   always begin
      @(negedge clk);
      if (rd_valid && !rd_ready && !rd_pend) begin
         if (rd_addr > 32'd255) begin
            $display("read from address %0h outside the modeled memory", rd_addr);
            status_errors++;
         end
         rd_pend = 1'b1;
         rd_wait = rand_bits(2);
      end
      if (wr_valid && !wr_ready && !wr_pend) begin
         wr_pend = 1'b1;
         if (long_stall && rand_bits(2) == 32'd0) begin
            wr_wait = 10 + rand_bits(3);
         end else begin
            wr_wait = rand_bits(2) % 3;
         end
      end
      @(posedge clk);
      #1;
      rd_ready = 1'b0;
      wr_ready = 1'b0;
      if (rd_pend) begin
         if (rd_wait == 0) begin
            rd_ready = 1'b1;
            rd_rdata = mem[rd_addr[7:0]];
            rd_pend  = 1'b0;
         end else begin
            rd_wait--;
         end
      end
      if (wr_pend) begin
         if (wr_wait == 0) begin
            wr_ready = 1'b1;
            wr_pend  = 1'b0;
         end else begin
            wr_wait--;
         end
      end
   end

   task automatic cpu_cycle(input logic v, input logic [31:0] a, input logic [31:0] d,
                            input logic s);
      @(posedge clk);
      #1;
      valid = v;
      addr  = a;
      wdata = d;
      wstrb = s;
   endtask

   task automatic cpu_idle(input int n);
      repeat (n) cpu_cycle(1'b0, '0, '0, 1'b0);
   endtask

   task automatic cfg_write(input logic [2:0] idx, input logic [31:0] d);
      cpu_cycle(1'b1, {27'b0, idx, 2'b00}, d, 1'b1);
   endtask

   task automatic check_status(input logic exp_done);
      @(negedge clk);
      if (ready !== 1'b1) begin
         $display("ERROR t=%0t ready expected 1 got %b", $time, ready);
         status_errors++;
      end
      if (rdata !== {31'b0, exp_done}) begin
         $display("ERROR t=%0t rdata expected %0h got %0h", $time, {31'b0, exp_done}, rdata);
         status_errors++;
      end
   endtask

   task automatic fill_random(input logic [7:0] base, input int count);
      for (int i = 0; i < count; i++) begin
         mem[base + i] = rand_word();
      end
   endtask

   // configure, queue expected writes, clear, run and wait for done
   task automatic run_layer(input logic [31:0] rd_base, input logic [31:0] wr_base,
                            input int count, input logic [3:0] shift,
                            input logic [31:0] coefs, input logic [31:0] bias, input int hold);
      cfg_write(`YOLO_REG_RD_BASE, rd_base);
      cfg_write(`YOLO_REG_WR_BASE, wr_base);
      cfg_write(`YOLO_REG_GEOM, {12'b0, shift, count[15:0]});
      cfg_write(`YOLO_REG_COEF, coefs);
      cfg_write(`YOLO_REG_BIAS, bias);
      for (int i = 0; i < count; i++) begin
         chk.push_expect(wr_base + i,
                         expected_result(mem[rd_base[7:0] + i], coefs, bias, shift));
      end
      cpu_cycle(1'b1, clear_addr, '0, 1'b0);
      cpu_idle(4);
      check_status(1'b0);
      // several cycles of run still start one layer
      for (int i = 0; i < hold; i++) begin
         cpu_cycle(1'b1, run_addr, '0, 1'b0);
      end
      cpu_idle(1);
      @(negedge clk);
      while (rdata[0] !== 1'b1) begin
         @(negedge clk);
      end
      check_status(1'b1);
      cpu_idle(20);
      chk.check_drained();
   endtask

   task automatic report_counts();
      $display("errors: values %0d, missing or extra writes %0d, status %0d, assertions %0d",
               chk.value_errors, chk.write_errors, status_errors, dut.props.fail_count);
   endtask

   initial begin : watchdog
      #(total_words * 200 * clk_period);
      $display("timeout, the DUT did not finish within %0d cycles", total_words * 200);
      report_counts();
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin : stimulus
      int          total;
      logic [31:0] coefs;
      logic [31:0] bias;
      rst      = 1'b0;
      valid    = 1'b0;
      addr     = '0;
      wdata    = '0;
      wstrb    = 1'b0;
      rd_rdata = '0;
      rd_ready = 1'b0;
      wr_ready = 1'b0;
      // reset edge comes after every process has started
      #1;
      rst = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;

      // basic layer
      fill_random(8'h10, 8);
      coefs = rand_bits(32);
      bias  = rand_bias();
      run_layer(32'h10, 32'h1000, 8, 4'd4, coefs, bias, 1);

      // clamp high, clamp low, small negatives through the leaky side
      mem[8'h20] = {4{16'h7fff}};
      mem[8'h21] = {4{16'h8000}};
      mem[8'h22] = {48'h0, 16'hffff};
      mem[8'h23] = {48'h0, 16'd258};
      mem[8'h24] = {48'h0, 16'd259};
      mem[8'h25] = {48'h0, 16'hfed4};
      run_layer(32'h20, 32'h2000, 6, 4'd0, 32'h7f7f7f7f, 32'h0, 1);

      // long write stalls over a longer layer
      long_stall = 1'b1;
      fill_random(8'h40, 16);
      coefs = rand_bits(32);
      bias  = rand_bias();
      run_layer(32'h40, 32'h3000, 16, 4'd5, coefs, bias, 1);
      long_stall = 1'b0;

      // run held four cycles, then an empty layer
      fill_random(8'h60, 4);
      coefs = rand_bits(32);
      bias  = rand_bias();
      run_layer(32'h60, 32'h4000, 4, 4'd3, coefs, bias, 4);
      run_layer(32'h60, 32'h4800, 0, 4'd3, coefs, bias, 1);

      // new bases, shift and coefficients
      fill_random(8'h80, 8);
      coefs = rand_bits(32);
      bias  = rand_bias();
      run_layer(32'h80, 32'h5000, 8, 4'd2, coefs, bias, 1);

      total = chk.value_errors + chk.write_errors + status_errors + dut.props.fail_count;
      report_counts();
      if (total == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: verif/yolo_checker.sv
`timescale 1ns/1ps
`include "yolo_params.svh"

module yolo_checker (
   input logic                        clk,
   input logic                        wr_valid,
   input logic                        wr_ready,
   input logic [`YOLO_MEM_ADDR_W-1:0] wr_addr,
   input logic [`YOLO_BUS_W-1:0]      wr_wdata,
   input logic [`YOLO_BUS_W/8-1:0]    wr_wstrb
);

   int value_errors = 0;
   int write_errors = 0;

   logic [`YOLO_MEM_ADDR_W-1:0] exp_addr [$];
   logic [`YOLO_BUS_W-1:0]      exp_data [$];

   task automatic push_expect(input logic [`YOLO_MEM_ADDR_W-1:0] a,
                              input logic [`YOLO_BUS_W-1:0] d);
      exp_addr.push_back(a);
      exp_data.push_back(d);
   endtask

   // anything still queued was never written
   task automatic check_drained();
      if (exp_addr.size() != 0) begin
         $display("%0d expected results were never written, first missing address %0h",
                  exp_addr.size(), exp_addr[0]);
         write_errors += exp_addr.size();
         exp_addr.delete();
         exp_data.delete();
      end
   endtask

   // at the falling edge, valid and ready show the write the next rising edge takes
   always @(negedge clk) begin
      logic [`YOLO_MEM_ADDR_W-1:0] ea;
      logic [`YOLO_BUS_W-1:0]      ed;
      if (wr_valid && wr_ready) begin
         if (exp_addr.size() == 0) begin
            $display("unexpected write of %h to address %0h, no result was pending",
                     wr_wdata, wr_addr);
            write_errors++;
         end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            if (wr_addr !== ea) begin
               $display("ERROR t=%0t wr_addr expected %0h got %0h", $time, ea, wr_addr);
               value_errors++;
            end
            if (wr_wdata !== ed) begin
               $display("ERROR t=%0t wr_wdata expected %h got %h", $time, ed, wr_wdata);
               value_errors++;
            end
            if (wr_wstrb !== '1) begin
               $display("ERROR t=%0t wr_wstrb expected %h got %h", $time,
                        {(`YOLO_BUS_W/8){1'b1}}, wr_wstrb);
               value_errors++;
            end
         end
      end
   end

endmodule

// File: verif/yolo_properties.sv
`timescale 1ns/1ps
`include "yolo_params.svh"

module yolo_properties (
   input logic                        clk,
   input logic                        rst,
   input logic                        rd_valid,
   input logic                        wr_valid,
   input logic                        wr_ready,
   input logic [`YOLO_MEM_ADDR_W-1:0] wr_addr,
   input logic [`YOLO_BUS_W-1:0]      wr_wdata,
   input logic                        run
);

   int fail_count = 0;

   // both databuses quiet while reset holds
   idle_in_reset: assert property (@(posedge clk) rst |-> !rd_valid && !wr_valid)
      else begin
         $error("rd_valid or wr_valid high during reset");
         fail_count++;
      end

   // a waiting write keeps its address and data
   write_stable: assert property (@(posedge clk) disable iff (rst)
      wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_wdata))
      else begin
         $error("write request changed before wr_ready");
         fail_count++;
      end

   run_single: assert property (@(posedge clk) disable iff (rst) run |=> !run)
      else begin
         $error("run pulse wider than one cycle");
         fail_count++;
      end

endmodule

// File: verilog/cfg_decode.sv
`timescale 1ns/1ps
`include "yolo_params.svh"

module cfg_decode (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    valid,
   input  logic [`YOLO_ADDR_W-1:0] addr,
   input  logic [`YOLO_DATA_W-1:0] wdata,
   input  logic                    wstrb,
   output logic                    ready,
   output logic [`YOLO_DATA_W-1:0] rdata,
   input  logic                    done,
   output yolo_pkg::layer_cfg_t    cfg,
   output logic                    run,
   output logic                    clear
);
   import yolo_pkg::*;

   logic      cmd;
   logic      run_cmd;
   logic      clear_cmd;
   logic      reg_wr;
   logic      run_r0;
   logic      run_r1;
   logic      clear_r0;
   cfg_word_u word;

   // commands live in the upper address bits
   assign cmd       = valid & addr[`YOLO_CMD_BIT];
   assign run_cmd   = cmd & ~addr[`YOLO_CLR_BIT];
   assign clear_cmd = cmd & addr[`YOLO_CLR_BIT];
   assign reg_wr    = valid & wstrb & ~addr[`YOLO_CMD_BIT];
   assign word      = wdata;

   // command registered, then edge detected into a single run pulse
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run_r0   <= 1'b0;
         run_r1   <= 1'b0;
         run      <= 1'b0;
         clear_r0 <= 1'b0;
         clear    <= 1'b0;
      end else begin
         run_r0   <= run_cmd;
         run_r1   <= run_r0;
         run      <= run_r0 & ~run_r1;
         clear_r0 <= clear_cmd;
         clear    <= clear_r0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg <= '0;
      end else if (reg_wr) begin
         case (addr[4:2])
            `YOLO_REG_RD_BASE: cfg.rd_base <= word.base;
            `YOLO_REG_WR_BASE: cfg.wr_base <= word.base;
            `YOLO_REG_GEOM: begin
               cfg.count <= word.geom.count;
               cfg.shift <= word.geom.shift;
            end
            // lane i coefficient sits in byte i
            `YOLO_REG_COEF:    cfg.coef <= wdata;
            `YOLO_REG_BIAS:    cfg.bias <= wdata;
            default: ;
         endcase
      end
   end

   // status read returns only done
   assign rdata = {{(`YOLO_DATA_W-1){1'b0}}, done};
   assign ready = 1'b1;

endmodule

// File: verilog/mac_datapath.sv
`timescale 1ns/1ps
`include "yolo_params.svh"

module mac_datapath (
   input  logic                 clk,
   input  logic                 rst,
   input  yolo_pkg::layer_cfg_t cfg,
   input  logic                 clear,
   input  yolo_pkg::flow_t      flow,
   input  logic                 flow_valid,
   output logic                 flow_ready,
   output yolo_pkg::result_t    res,
   output logic                 res_valid,
   input  logic                 res_ready
);
   import yolo_pkg::*;

   logic               advance;
   logic               s1_valid;
   logic               s1_last;
   logic signed [23:0] s1_prod [`YOLO_LANES];
   logic signed [33:0] acc;
   logic signed [33:0] shifted;
   logic signed [33:0] leaky;
   lane_t              sat;

   // both stages move together or freeze together
   assign advance    = res_ready | ~res_valid;
   assign flow_ready = advance;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         s1_valid  <= 1'b0;
         res_valid <= 1'b0;
      end else if (clear) begin
         s1_valid  <= 1'b0;
         res_valid <= 1'b0;
      end else if (advance) begin
         s1_valid  <= flow_valid;
         res_valid <= s1_valid;
      end
   end

   // stage one, 16x8 signed lane products
   always_ff @(posedge clk) begin
      if (advance) begin
         for (int i = 0; i < `YOLO_LANES; i++) begin
            s1_prod[i] <= lane_t'(flow.word[16*i +: 16]) * cfg.coef[i];
         end
         s1_last <= flow.last;
      end
   end

   // stage two math, wide enough for bias plus four products
   always_comb begin
      acc = 34'(cfg.bias);
      for (int i = 0; i < `YOLO_LANES; i++) begin
         acc = acc + s1_prod[i];
      end
      shifted = acc >>> cfg.shift;
      // leaky relu, negative side divided by 8
      leaky = shifted[33] ? (shifted >>> 3) : shifted;
      if (leaky > 34'sd32767) begin
         sat = 16'sh7fff;
      end else if (leaky < -34'sd32768) begin
         sat = 16'sh8000;
      end else begin
         sat = leaky[15:0];
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         res.value <= sat;
         res.last  <= s1_last;
      end
   end

endmodule

// File: verilog/result_store.sv
`timescale 1ns/1ps
`include "yolo_params.svh"

module result_store (
   input  logic                        clk,
   input  logic                        rst,
   input  yolo_pkg::layer_cfg_t        cfg,
   input  logic                        run,
   input  logic                        clear,
   input  yolo_pkg::result_t           res,
   input  logic                        res_valid,
   output logic                        res_ready,
   output logic                        wr_valid,
   output logic [`YOLO_MEM_ADDR_W-1:0] wr_addr,
   output logic [`YOLO_BUS_W-1:0]      wr_wdata,
   output logic [`YOLO_BUS_W/8-1:0]    wr_wstrb,
   input  logic                        wr_ready,
   output logic                        done
);

   logic last_q;
   logic accept;
   logic wr_done;

   // one slot, refilled in the cycle its write is taken
   assign res_ready = ~wr_valid | wr_ready;
   assign accept    = res_valid & res_ready;
   assign wr_done   = wr_valid & wr_ready;
   assign wr_wstrb  = '1;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_valid <= 1'b0;
         wr_addr  <= '0;
         done     <= 1'b0;
      end else if (clear) begin
         wr_valid <= 1'b0;
         done     <= 1'b0;
      end else begin
         if (run) begin
            wr_addr <= cfg.wr_base;
            // empty layer finishes at once
            done    <= (cfg.count == 16'd0);
         end else if (wr_done) begin
            wr_addr <= wr_addr + 1'b1;
            if (last_q) begin
               done <= 1'b1;
            end
         end
         if (accept) begin
            wr_valid <= 1'b1;
         end else if (wr_done) begin
            wr_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         wr_wdata <= {{(`YOLO_BUS_W-16){res.value[15]}}, res.value};
         last_q   <= res.last;
      end
   end

endmodule

// File: verilog/vec_fetch.sv
`timescale 1ns/1ps
`include "yolo_params.svh"

module vec_fetch (
   input  logic                        clk,
   input  logic                        rst,
   input  yolo_pkg::layer_cfg_t        cfg,
   input  logic                        run,
   input  logic                        clear,
   output logic                        rd_valid,
   output logic [`YOLO_MEM_ADDR_W-1:0] rd_addr,
   input  logic [`YOLO_BUS_W-1:0]      rd_rdata,
   input  logic                        rd_ready,
   output yolo_pkg::flow_t             flow,
   output logic                        flow_valid,
   input  logic                        flow_ready
);

   logic                        busy;
   logic                        take;
   logic [15:0]                 remaining;
   logic [`YOLO_MEM_ADDR_W-1:0] addr_q;

   // request only while the datapath can take the word
   assign rd_valid = busy & flow_ready;
   assign rd_addr  = addr_q;
   assign take     = rd_valid & rd_ready;

   // returned word forwarded in the same cycle
   assign flow_valid = take;
   assign flow.word  = rd_rdata;
   assign flow.last  = (remaining == 16'd1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         remaining <= '0;
         addr_q    <= '0;
      end else if (clear) begin
         busy      <= 1'b0;
         remaining <= '0;
      end else if (run) begin
         // zero count never goes busy
         busy      <= (cfg.count != 16'd0);
         remaining <= cfg.count;
         addr_q    <= cfg.rd_base;
      end else if (take) begin
         addr_q    <= addr_q + 1'b1;
         remaining <= remaining - 16'd1;
         if (remaining == 16'd1) begin
            busy <= 1'b0;
         end
      end
   end

endmodule

// File: verilog/yolo_accel.sv
`timescale 1ns/1ps
`include "yolo_params.svh"

module yolo_accel (
   input  logic                        clk,
   input  logic                        rst,
   // cpu port
   input  logic                        valid,
   input  logic [`YOLO_ADDR_W-1:0]     addr,
   input  logic [`YOLO_DATA_W-1:0]     wdata,
   input  logic                        wstrb,
   output logic                        ready,
   output logic [`YOLO_DATA_W-1:0]     rdata,
   // read databus
   output logic                        rd_valid,
   output logic [`YOLO_MEM_ADDR_W-1:0] rd_addr,
   input  logic [`YOLO_BUS_W-1:0]      rd_rdata,
   input  logic                        rd_ready,
   // write databus
   output logic                        wr_valid,
   output logic [`YOLO_MEM_ADDR_W-1:0] wr_addr,
   output logic [`YOLO_BUS_W-1:0]      wr_wdata,
   output logic [`YOLO_BUS_W/8-1:0]    wr_wstrb,
   input  logic                        wr_ready
);
   import yolo_pkg::*;

   layer_cfg_t cfg;
   flow_t      flow;
   result_t    res;
   logic       run, clear, done;
   logic       flow_valid, flow_ready;
   logic       res_valid, res_ready;

   cfg_decode u_decode (
      .clk(clk), .rst(rst), .valid(valid), .addr(addr), .wdata(wdata),
      .wstrb(wstrb), .ready(ready), .rdata(rdata), .done(done),
      .cfg(cfg), .run(run), .clear(clear)
   );

   vec_fetch u_fetch (
      .clk(clk), .rst(rst), .cfg(cfg), .run(run), .clear(clear),
      .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_rdata(rd_rdata), .rd_ready(rd_ready),
      .flow(flow), .flow_valid(flow_valid), .flow_ready(flow_ready)
   );

   mac_datapath u_mac (
      .clk(clk), .rst(rst), .cfg(cfg), .clear(clear),
      .flow(flow), .flow_valid(flow_valid), .flow_ready(flow_ready),
      .res(res), .res_valid(res_valid), .res_ready(res_ready)
   );

   result_store u_store (
      .clk(clk), .rst(rst), .cfg(cfg), .run(run), .clear(clear),
      .res(res), .res_valid(res_valid), .res_ready(res_ready),
      .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_wdata(wr_wdata),
      .wr_wstrb(wr_wstrb), .wr_ready(wr_ready), .done(done)
   );

endmodule

// File: verilog/yolo_pkg.sv
`include "yolo_params.svh"

package yolo_pkg;

   // one signed lane of a databus word and one signed coefficient
   typedef logic signed [15:0] lane_t;
   typedef logic signed [7:0]  coef_t;

   // geometry view of a configuration word
   typedef struct packed {
      logic [11:0] rsvd;
      logic [3:0]  shift;
      logic [15:0] count;
   } geom_t;

   // one cpu write word, seen as a base address or as geometry
   typedef union packed {
      logic [`YOLO_DATA_W-1:0] base;
      geom_t                   geom;
   } cfg_word_u;

   typedef struct packed {
      logic [`YOLO_MEM_ADDR_W-1:0] rd_base;
      logic [`YOLO_MEM_ADDR_W-1:0] wr_base;
      logic [15:0]                 count;
      logic [3:0]                  shift;
      coef_t [`YOLO_LANES-1:0]     coef;
      logic signed [31:0]          bias;
   } layer_cfg_t;

   // fetched word on its way to the datapath
   typedef struct packed {
      logic [`YOLO_BUS_W-1:0] word;
      logic                   last;
   } flow_t;

   typedef struct packed {
      lane_t value;
      logic  last;
   } result_t;

endpackage
